// ==== verilog.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/fetch_unit.sv
verilog/lsu_port.sv
verilog/axil_arbiter.sv
verilog/cpu_bus_wrapper.sv
bench/axil_mem_model.sv
bench/tb_cpu_bus_wrapper.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_bus_wrapper
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_cpu_bus_wrapper.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module tb_cpu_bus_wrapper;
    import bus_pkg::*;

    localparam int NUM_LSU   = 50;          // Directed plus mixed requests
    localparam int NUM_INSTR = 56;          // Instructions waited for
    localparam int WORST     = 36;          // Cycles per item under back-pressure
    localparam int LIMIT     = (NUM_LSU + NUM_INSTR) * WORST;
    localparam logic [31:0] STORE_BASE = 32'h8000_0c00;   // Kept away from fetch range

    logic clock, rst, instr_ready, instr_valid, redirect_valid;
    logic lsu_req_valid, lsu_req_ready, lsu_rsp_valid, lsu_rsp_ready;
    logic m_arvalid, m_arready, m_rvalid, m_rready, m_awvalid, m_awready;
    logic m_wvalid, m_wready, m_bvalid, m_bready;
    logic [31:0] redirect_pc, rnd, exp_pc;
    instr_t   instr;
    lsu_req_t lsu_req;
    lsu_rsp_t lsu_rsp, exp_rsp;
    axil_ar_t m_ar;
    axil_r_t  m_r;
    axil_aw_t m_aw;
    axil_w_t  m_w;
    axil_b_t  m_b;
    logic        exp_pending;
    int          pop_count, cycles;
    logic [31:0] shadow [logic [29:0]];     // Expected memory words after stores

    cpu_bus_wrapper cpu_bus_wrapper_i (.*);

    axil_mem_model mem_u0 (
        .clock(clock), .rst(rst), .rnd(rnd),
        .ar(m_ar), .arvalid(m_arvalid), .arready(m_arready),
        .r(m_r), .rvalid(m_rvalid), .rready(m_rready),
        .aw(m_aw), .awvalid(m_awvalid), .awready(m_awready),
        .w(m_w), .wvalid(m_wvalid), .wready(m_wready),
        .b(m_b), .bvalid(m_bvalid), .bready(m_bready)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Content rule with earlier stores merged in
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, data,
                                                input logic [3:0] strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) old[8*i +: 8] = data[8*i +: 8];
        end
        return old;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp, act);
        $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        abort_run();
    endtask

    task automatic report_error(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        abort_run();
    endtask

    always #4 clock = ~clock;

    always @(posedge clock) begin
        rnd           <= next_random(rnd);
        instr_ready   <= rnd[4] | rnd[9];   // Mostly ready
        lsu_rsp_ready <= rnd[5] | rnd[8];
        cycles        <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles", cycles);
            abort_run();
        end
    end

    // Reference state for the checks
    always @(posedge clock) begin
        if (rst) begin
            exp_pc      <= `BUS_RESET_VECTOR;
            pop_count   <= 0;
            exp_pending <= 1'b0;
        end else begin
            if (redirect_valid) exp_pc <= redirect_pc;   // Redirect wins over a pop
            else if (instr_valid && instr_ready) exp_pc <= exp_pc + 4;
            if (instr_valid && instr_ready) pop_count <= pop_count + 1;
            if (lsu_req_valid && lsu_req_ready) begin
                exp_pending   <= 1'b1;
                exp_rsp.err   <= (lsu_req.addr >= `BUS_MEM_TOP);
                exp_rsp.rdata <= (lsu_req.op == LSU_LOAD) ? expected_word(lsu_req.addr) : '0;
                if (lsu_req.op == LSU_STORE && lsu_req.addr < `BUS_MEM_TOP) begin
                    shadow[lsu_req.addr[31:2]] = merge_bytes(expected_word(lsu_req.addr),
                                                             lsu_req.wdata, lsu_req.wstrb);
                end
            end else if (lsu_rsp_valid && lsu_rsp_ready) exp_pending <= 1'b0;
        end
    end

    // Quiet outputs right after reset
    a_reset_quiet: assert property (@(posedge clock) $fell(rst) |-> !m_arvalid && !m_awvalid
        && !m_wvalid && !instr_valid && !lsu_rsp_valid)
        else report_error("an output valid was high right after reset");
    a_instr_pc: assert property (@(posedge clock) disable iff (rst)
        instr_valid && instr_ready |-> instr.pc == exp_pc)
        else report_mismatch("instr.pc", $sampled(exp_pc), $sampled(instr.pc));
    a_instr_err: assert property (@(posedge clock) disable iff (rst)
        instr_valid && instr_ready |-> instr.err == (instr.pc >= `BUS_MEM_TOP))
        else report_mismatch("instr.err", 32'($sampled(instr.pc) >= `BUS_MEM_TOP),
                             32'($sampled(instr.err)));
    a_instr_data: assert property (@(posedge clock) disable iff (rst)
        instr_valid && instr_ready && !instr.err |-> instr.data == expected_word(instr.pc))
        else report_mismatch("instr.data", expected_word($sampled(instr.pc)),
                             $sampled(instr.data));
    a_rsp_expected: assert property (@(posedge clock) disable iff (rst)
        lsu_rsp_valid && lsu_rsp_ready |-> exp_pending)
        else report_error("load/store response without a request");
    a_rsp_err: assert property (@(posedge clock) disable iff (rst)
        lsu_rsp_valid && lsu_rsp_ready |-> lsu_rsp.err == exp_rsp.err)
        else report_mismatch("lsu_rsp.err", 32'($sampled(exp_rsp.err)),
                             32'($sampled(lsu_rsp.err)));
    a_rsp_data: assert property (@(posedge clock) disable iff (rst)
        lsu_rsp_valid && lsu_rsp_ready && !exp_rsp.err |-> lsu_rsp.rdata == exp_rsp.rdata)
        else report_mismatch("lsu_rsp.rdata", $sampled(exp_rsp.rdata), $sampled(lsu_rsp.rdata));
    a_rsp_stable: assert property (@(posedge clock) disable iff (rst)
        lsu_rsp_valid && !lsu_rsp_ready |=> lsu_rsp_valid && $stable(lsu_rsp))
        else report_error("lsu_rsp changed or dropped while held");

    task automatic redirect_to(input logic [31:0] pc);
        @(posedge clock);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        @(posedge clock);
        redirect_valid <= 1'b0;
    endtask

    task automatic wait_instrs(input int n);
        int target;
        target = pop_count + n;
        while (pop_count < target) @(posedge clock);
    endtask

    // One request and a wait for its response handshake
    task automatic issue_lsu(input lsu_op_e op, input logic [31:0] addr, data,
                             input logic [3:0] strb);
        @(posedge clock);
        lsu_req       <= '{op: op, addr: addr, wdata: data, wstrb: strb};
        lsu_req_valid <= 1'b1;
        do @(posedge clock); while (!lsu_req_ready);
        lsu_req_valid <= 1'b0;
        do @(posedge clock); while (!(lsu_rsp_valid && lsu_rsp_ready));
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        clock = 1'b0;
        rst = 1'b1;
        rnd = 32'h3def_4cee;
        cycles = 0;
        instr_ready = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        lsu_req = '0;
        lsu_req_valid = 1'b0;
        lsu_rsp_ready = 1'b0;
        repeat (10) @(posedge clock);
        rst <= 1'b0;
        wait_instrs(20);                                    // Sequential fetch
        issue_lsu(LSU_STORE, STORE_BASE, 32'h1122_3344, 4'hf);
        issue_lsu(LSU_LOAD, STORE_BASE, '0, '0);
        issue_lsu(LSU_STORE, STORE_BASE + 4, 32'haabb_ccdd, 4'b0101);
        issue_lsu(LSU_LOAD, STORE_BASE + 4, '0, '0);
        issue_lsu(LSU_STORE, STORE_BASE + 8, 32'h9900_0000, 4'b1000);
        issue_lsu(LSU_LOAD, STORE_BASE + 8, '0, '0);
        issue_lsu(LSU_LOAD, STORE_BASE + 12, '0, '0);       // Never written
        issue_lsu(LSU_STORE, `BUS_MEM_TOP + 4, 32'hdead_beef, 4'hf);
        issue_lsu(LSU_LOAD, `BUS_MEM_TOP, '0, '0);
        issue_lsu(LSU_LOAD, `BUS_MEM_TOP + 8, '0, '0);
        redirect_to(32'h8000_0100);
        wait_instrs(10);
        redirect_to(`BUS_MEM_TOP - 8);                      // Runs into the error range
        wait_instrs(6);
        redirect_to(`BUS_RESET_VECTOR);
        for (int i = 0; i < NUM_LSU - 10; i++) begin       // Mixed traffic
            r = rnd;
            repeat (r[2:0]) @(posedge clock);
            if (i % 8 == 0) redirect_to(32'h8000_0000 | {21'd0, r[10:2], 2'b00});
            if (r[15:13] == 3'b111) addr = `BUS_MEM_TOP | {26'd0, r[19:16], 2'b00};
            else addr = STORE_BASE | {26'd0, r[19:16], 2'b00};
            issue_lsu(r[11] ? LSU_STORE : LSU_LOAD, addr, next_random(r), r[23:20]);
        end
        wait_instrs(20);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== bench/axil_mem_model.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module axil_mem_model (
    input  logic              clock,
    input  logic              rst,
    input  logic [31:0]       rnd,          // Random bits from the bench, new every cycle
    input  bus_pkg::axil_ar_t ar,
    input  logic              arvalid,
    output logic              arready,
    output bus_pkg::axil_r_t  r,
    output logic              rvalid,
    input  logic              rready,
    input  bus_pkg::axil_aw_t aw,
    input  logic              awvalid,
    output logic              awready,
    input  bus_pkg::axil_w_t  w,
    input  logic              wvalid,
    output logic              wready,
    output bus_pkg::axil_b_t  b,
    output logic              bvalid,
    input  logic              bready
);
    import bus_pkg::*;

    logic [31:0] mem [logic [29:0]];       // Written words only, by word address
    logic        rd_pend;
    logic [31:0] rd_addr;
    logic        aw_got;
    logic        w_got;
    axil_aw_t    aw_q;
    axil_w_t     w_q;
    logic [31:0] merged;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) return mem[addr[31:2]];
        return addr ^ 32'h5a5a_5a5a;        // Untouched memory
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        r       = '0;
        b       = '0;
    end

    always @(posedge clock) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_pend <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_pend <= 1'b1;
                rd_addr <= ar.addr;
            end else arready <= !rd_pend && rnd[0];    // Random address stall
            if (rd_pend && !rvalid && rnd[2]) begin    // Random data delay
                rvalid <= 1'b1;
                if (rd_addr >= `BUS_MEM_TOP) r <= '{data: '0, resp: 2'b10};
                else r <= '{data: read_word(rd_addr), resp: 2'b00};
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_pend <= 1'b0;
            end
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                aw_q    <= aw;
                awready <= 1'b0;
            end else awready <= !aw_got && rnd[1];
            if (wvalid && wready) begin
                w_got  <= 1'b1;
                w_q    <= w;
                wready <= 1'b0;
            end else wready <= !w_got && rnd[3];
            if (aw_got && w_got && !bvalid && rnd[6]) begin
                merged = read_word(aw_q.addr);
                for (int i = 0; i < 4; i++) begin
                    if (w_q.strb[i]) merged[8*i +: 8] = w_q.data[8*i +: 8];
                end
                if (aw_q.addr < `BUS_MEM_TOP) mem[aw_q.addr[31:2]] = merged;
                b.resp <= (aw_q.addr >= `BUS_MEM_TOP) ? 2'b10 : 2'b00;   // SLVERR above top
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
            if (bvalid && bready) bvalid <= 1'b0;
        end
    end

endmodule

// ==== verilog/cpu_bus_wrapper.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module cpu_bus_wrapper (
    input  logic                       clock,
    input  logic                       rst,
    // Instruction stream
    output bus_pkg::instr_t            instr,
    output logic                       instr_valid,
    input  logic                       instr_ready,
    input  logic                       redirect_valid,
    input  logic [`BUS_ADDR_WIDTH-1:0] redirect_pc,
    // Load/store requests
    input  bus_pkg::lsu_req_t          lsu_req,
    input  logic                       lsu_req_valid,
    output logic                       lsu_req_ready,
    output bus_pkg::lsu_rsp_t          lsu_rsp,
    output logic                       lsu_rsp_valid,
    input  logic                       lsu_rsp_ready,
    // External AXI4-Lite master
    output bus_pkg::axil_ar_t          m_ar,
    output logic                       m_arvalid,
    input  logic                       m_arready,
    input  bus_pkg::axil_r_t           m_r,
    input  logic                       m_rvalid,
    output logic                       m_rready,
    output bus_pkg::axil_aw_t          m_aw,
    output logic                       m_awvalid,
    input  logic                       m_awready,
    output bus_pkg::axil_w_t           m_w,
    output logic                       m_wvalid,
    input  logic                       m_wready,
    input  bus_pkg::axil_b_t           m_b,
    input  logic                       m_bvalid,
    output logic                       m_bready
);
    import bus_pkg::*;

    axil_ar_t fetch_ar;                             // Fetch to arbiter
    logic     fetch_arvalid;
    logic     fetch_arready;
    axil_r_t  fetch_r;
    logic     fetch_rvalid;
    logic     fetch_rready;
    axil_ar_t lsu_ar;                               // Load/store to arbiter
    logic     lsu_arvalid;
    logic     lsu_arready;
    axil_r_t  lsu_r;
    logic     lsu_rvalid;
    logic     lsu_rready;
    axil_aw_t lsu_aw;
    logic     lsu_awvalid;
    logic     lsu_awready;
    axil_w_t  lsu_w;
    logic     lsu_wvalid;
    logic     lsu_wready;
    axil_b_t  lsu_b;
    logic     lsu_bvalid;
    logic     lsu_bready;

    // Port names match the nets above
    fetch_unit fetch_unit_u0 (.*);

    lsu_port lsu_port_u0 (.*);

    axil_arbiter axil_arbiter_u0 (.*);

endmodule

// ==== verilog/axil_arbiter.sv ====
`timescale 1ns/1ps

module axil_arbiter (
    input  logic                clock,
    input  logic                rst,
    // Fetch read side
    input  bus_pkg::axil_ar_t   fetch_ar,
    input  logic                fetch_arvalid,
    output logic                fetch_arready,
    output bus_pkg::axil_r_t    fetch_r,
    output logic                fetch_rvalid,
    input  logic                fetch_rready,
    // Load/store side
    input  bus_pkg::axil_ar_t   lsu_ar,
    input  logic                lsu_arvalid,
    output logic                lsu_arready,
    output bus_pkg::axil_r_t    lsu_r,
    output logic                lsu_rvalid,
    input  logic                lsu_rready,
    input  bus_pkg::axil_aw_t   lsu_aw,
    input  logic                lsu_awvalid,
    output logic                lsu_awready,
    input  bus_pkg::axil_w_t    lsu_w,
    input  logic                lsu_wvalid,
    output logic                lsu_wready,
    output bus_pkg::axil_b_t    lsu_b,
    output logic                lsu_bvalid,
    input  logic                lsu_bready,
    // External master
    output bus_pkg::axil_ar_t   m_ar,
    output logic                m_arvalid,
    input  logic                m_arready,
    input  bus_pkg::axil_r_t    m_r,
    input  logic                m_rvalid,
    output logic                m_rready,
    output bus_pkg::axil_aw_t   m_aw,
    output logic                m_awvalid,
    input  logic                m_awready,
    output bus_pkg::axil_w_t    m_w,
    output logic                m_wvalid,
    input  logic                m_wready,
    input  bus_pkg::axil_b_t    m_b,
    input  logic                m_bvalid,
    output logic                m_bready
);
    import bus_pkg::*;

    arb_state_e state_q;
    logic       grant_lsu_q;                        // Last winner and current owner of R
    axil_ar_t   ar_q;                               // Winning address
    logic       pick_lsu;
    logic       any_req;

    // Round robin between the two readers
    assign pick_lsu = lsu_arvalid && (!fetch_arvalid || !grant_lsu_q);
    assign any_req  = fetch_arvalid || lsu_arvalid;

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q     <= ARB_IDLE;
            grant_lsu_q <= 1'b0;                    // Fetch counts as last winner
        end else begin
            unique case (state_q)
                ARB_IDLE: begin
                    if (any_req) begin
                        state_q     <= ARB_ADDR;
                        grant_lsu_q <= pick_lsu;
                    end
                end
                ARB_ADDR: if (m_arready) state_q <= ARB_DATA;
                ARB_DATA: if (m_rvalid && m_rready) state_q <= ARB_IDLE;
                default:  state_q <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == ARB_IDLE && any_req) begin
            ar_q <= pick_lsu ? lsu_ar : fetch_ar;   // Held stable through ARB_ADDR
        end
    end

    // Winner is accepted in the request cycle
    assign fetch_arready = (state_q == ARB_IDLE) && fetch_arvalid && !pick_lsu;
    assign lsu_arready   = (state_q == ARB_IDLE) && pick_lsu;

    assign m_ar      = ar_q;
    assign m_arvalid = (state_q == ARB_ADDR);

    // Read data goes only to the grant holder
    assign fetch_r      = m_r;
    assign lsu_r        = m_r;
    assign fetch_rvalid = (state_q == ARB_DATA) && !grant_lsu_q && m_rvalid;
    assign lsu_rvalid   = (state_q == ARB_DATA) && grant_lsu_q && m_rvalid;
    assign m_rready     = (state_q == ARB_DATA) && (grant_lsu_q ? lsu_rready : fetch_rready);

    // Only the load/store port writes
    assign m_aw        = lsu_aw;
    assign m_awvalid   = lsu_awvalid;
    assign lsu_awready = m_awready;
    assign m_w         = lsu_w;
    assign m_wvalid    = lsu_wvalid;
    assign lsu_wready  = m_wready;
    assign lsu_b       = m_b;
    assign lsu_bvalid  = m_bvalid;
    assign m_bready    = lsu_bready;

endmodule

// ==== verilog/lsu_port.sv ====
`timescale 1ns/1ps

module lsu_port (
    input  logic                clock,
    input  logic                rst,
    input  bus_pkg::lsu_req_t   lsu_req,
    input  logic                lsu_req_valid,
    output logic                lsu_req_ready,
    output bus_pkg::lsu_rsp_t   lsu_rsp,
    output logic                lsu_rsp_valid,
    input  logic                lsu_rsp_ready,
    output bus_pkg::axil_ar_t   lsu_ar,
    output logic                lsu_arvalid,
    input  logic                lsu_arready,
    input  bus_pkg::axil_r_t    lsu_r,
    input  logic                lsu_rvalid,
    output logic                lsu_rready,
    output bus_pkg::axil_aw_t   lsu_aw,
    output logic                lsu_awvalid,
    input  logic                lsu_awready,
    output bus_pkg::axil_w_t    lsu_w,
    output logic                lsu_wvalid,
    input  logic                lsu_wready,
    input  bus_pkg::axil_b_t    lsu_b,
    input  logic                lsu_bvalid,
    output logic                lsu_bready
);
    import bus_pkg::*;

    localparam logic [2:0] PROT_DATA = 3'b000;      // Unprivileged data access

    lsu_state_e state_q;
    lsu_req_t   req_q;                              // Captured request
    lsu_rsp_t   rsp_q;
    logic       aw_done_q;                          // AW already accepted
    logic       w_done_q;                           // W already accepted
    logic       aw_done;
    logic       w_done;

    assign aw_done = aw_done_q || (lsu_awvalid && lsu_awready);
    assign w_done  = w_done_q || (lsu_wvalid && lsu_wready);

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q   <= LSU_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            unique case (state_q)
                LSU_IDLE: begin
                    if (lsu_req_valid) begin
                        if (lsu_req.op == LSU_STORE) state_q <= LSU_WRITE;
                        else state_q <= LSU_RADDR;
                    end
                end
                LSU_RADDR: if (lsu_arready) state_q <= LSU_RDATA;
                LSU_RDATA: if (lsu_rvalid) state_q <= LSU_DONE;
                LSU_WRITE: begin
                    if (aw_done && w_done) begin    // Both channels through
                        state_q   <= LSU_WRESP;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end else begin
                        aw_done_q <= aw_done;
                        w_done_q  <= w_done;
                    end
                end
                LSU_WRESP: if (lsu_bvalid) state_q <= LSU_DONE;
                LSU_DONE:  if (lsu_rsp_ready) state_q <= LSU_IDLE;
                default:   state_q <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (lsu_req_valid && lsu_req_ready) req_q <= lsu_req;
        if (lsu_rvalid && lsu_rready) begin
            rsp_q <= '{rdata: lsu_r.data, err: |lsu_r.resp};
        end else if (lsu_bvalid && lsu_bready) begin
            rsp_q <= '{rdata: '0, err: |lsu_b.resp};   // Stores return no data
        end
    end

    assign lsu_req_ready = (state_q == LSU_IDLE);
    assign lsu_arvalid   = (state_q == LSU_RADDR);
    assign lsu_rready    = (state_q == LSU_RDATA);
    assign lsu_awvalid   = (state_q == LSU_WRITE) && !aw_done_q;  // Drops on its own handshake
    assign lsu_wvalid    = (state_q == LSU_WRITE) && !w_done_q;
    assign lsu_bready    = (state_q == LSU_WRESP);
    assign lsu_rsp_valid = (state_q == LSU_DONE);   // Held until taken
    assign lsu_rsp       = rsp_q;

    assign lsu_ar = '{addr: req_q.addr, prot: PROT_DATA};
    assign lsu_aw = '{addr: req_q.addr, prot: PROT_DATA};
    assign lsu_w  = '{data: req_q.wdata, strb: req_q.wstrb};

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps
`include "bus_settings.svh"

module fetch_unit (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       redirect_valid,  // Single-cycle jump
    input  logic [`BUS_ADDR_WIDTH-1:0] redirect_pc,
    output bus_pkg::axil_ar_t          fetch_ar,
    output logic                       fetch_arvalid,
    input  logic                       fetch_arready,
    input  bus_pkg::axil_r_t           fetch_r,
    input  logic                       fetch_rvalid,
    output logic                       fetch_rready,
    output bus_pkg::instr_t            instr,
    output logic                       instr_valid,
    input  logic                       instr_ready
);
    import bus_pkg::*;

    localparam int         DEPTH      = `FETCH_DEPTH;
    localparam int         PTR_W      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W:0] FULL   = (PTR_W + 1)'(DEPTH);
    localparam logic [2:0] PROT_INSTR = 3'b100;     // Unprivileged instruction fetch

    logic [`BUS_ADDR_WIDTH-1:0] next_pc_q;          // Address of the next read to issue
    logic [`BUS_ADDR_WIDTH-1:0] ar_addr_q;          // Address of the read in flight
    logic                       arvalid_q;
    logic                       outstanding_q;      // AR accepted, R pending
    logic                       discard_q;          // Drop the next response
    instr_t                     ibuf_q [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [PTR_W:0]             count_q;
    logic                       ar_hs;
    logic                       r_hs;
    logic                       push;
    logic                       pop;
    logic                       issue;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;   // Wrap for any depth
    endfunction

    assign ar_hs = fetch_arvalid && fetch_arready;
    assign r_hs  = fetch_rvalid && fetch_rready;
    assign push  = r_hs && !discard_q;              // Stale data never enters the buffer
    assign pop   = instr_valid && instr_ready;
    // One read at a time; room is reserved before the read goes out
    assign issue = !arvalid_q && !outstanding_q && !redirect_valid && (count_q < FULL);

    always_ff @(posedge clock) begin
        if (rst) begin
            arvalid_q     <= 1'b1;                  // First read right after reset
            ar_addr_q     <= `BUS_RESET_VECTOR;
            next_pc_q     <= `BUS_RESET_VECTOR + 4;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
        end else begin
            if (ar_hs) begin
                arvalid_q     <= 1'b0;
                outstanding_q <= 1'b1;
            end else if (issue) begin
                arvalid_q <= 1'b1;
                ar_addr_q <= next_pc_q;
                next_pc_q <= next_pc_q + 4;         // Sequential word fetch
            end
            if (r_hs) begin
                outstanding_q <= 1'b0;
                discard_q     <= 1'b0;
            end
            if (redirect_valid) begin
                next_pc_q <= redirect_pc;
                // Pending AR still goes out, its data is thrown away
                discard_q <= arvalid_q || (outstanding_q && !r_hs);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (redirect_valid) begin
            wr_ptr_q <= '0;                         // Flush everything buffered
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            unique case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // Both or neither
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            ibuf_q[wr_ptr_q] <= '{pc: ar_addr_q, data: fetch_r.data, err: |fetch_r.resp};
        end
    end

    assign fetch_ar      = '{addr: ar_addr_q, prot: PROT_INSTR};
    assign fetch_arvalid = arvalid_q;
    assign fetch_rready  = outstanding_q;           // Slot already reserved
    assign instr_valid   = (count_q != '0);
    assign instr         = ibuf_q[rd_ptr_q];        // Head entry

endmodule

// ==== verilog/bus_pkg.sv ====
`include "bus_settings.svh"

package bus_pkg;

    // Read address channel payload
    typedef struct packed {
        logic [`BUS_ADDR_WIDTH-1:0] addr;
        logic [2:0]                 prot;       // Bit 2 marks instruction access
    } axil_ar_t;

    // Read data channel payload
    typedef struct packed {
        logic [`BUS_DATA_WIDTH-1:0] data;
        logic [1:0]                 resp;       // OKAY when zero
    } axil_r_t;

    typedef struct packed {
        logic [`BUS_ADDR_WIDTH-1:0] addr;
        logic [2:0]                 prot;
    } axil_aw_t;

    typedef struct packed {
        logic [`BUS_DATA_WIDTH-1:0]   data;
        logic [`BUS_DATA_WIDTH/8-1:0] strb;     // One bit per byte lane
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_op_e;

    // Single load or store from the core side
    typedef struct packed {
        lsu_op_e                      op;
        logic [`BUS_ADDR_WIDTH-1:0]   addr;
        logic [`BUS_DATA_WIDTH-1:0]   wdata;    // Ignored for loads
        logic [`BUS_DATA_WIDTH/8-1:0] wstrb;
    } lsu_req_t;

    typedef struct packed {
        logic [`BUS_DATA_WIDTH-1:0] rdata;      // Zero for stores
        logic                       err;        // Any non-OKAY response
    } lsu_rsp_t;

    // One buffered instruction word
    typedef struct packed {
        logic [`BUS_ADDR_WIDTH-1:0] pc;
        logic [`BUS_DATA_WIDTH-1:0] data;
        logic                       err;
    } instr_t;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,                        // Waiting for a read request
        ARB_ADDR = 2'd1,                        // Address out on m_ar
        ARB_DATA = 2'd2                         // Waiting for m_r
    } arb_state_e;

    typedef enum logic [2:0] {
        LSU_IDLE  = 3'd0,
        LSU_RADDR = 3'd1,
        LSU_RDATA = 3'd2,
        LSU_WRITE = 3'd3,                       // AW and W in flight
        LSU_WRESP = 3'd4,
        LSU_DONE  = 3'd5                        // Holding the response
    } lsu_state_e;

endpackage

// ==== verilog/bus_settings.svh ====
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// Byte address width of every channel
`define BUS_ADDR_WIDTH 32

// Data width of read and write channels
`define BUS_DATA_WIDTH 32

// Address of the first instruction fetch
`define BUS_RESET_VECTOR 32'h8000_0000

// Entries in the instruction buffer
`define FETCH_DEPTH 4

// First address above the memory that answers with an error
`define BUS_MEM_TOP 32'h8000_1000

`endif
